//--- build.f
source/csr_map_pkg.sv
source/csr_field_pkg.sv
source/csr_rmw.sv
source/csr_counters.sv
source/csr_trap_ctrl.sv
source/csr_regfile.sv
source/csr_unit.sv
verif/csr_checker.sv
verif/csr_unit_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module csr_unit_tb -o csr_sim

out=$(./obj_dir/csr_sim)
echo "$out"

echo "$out" | grep -q "^TESTS PASSED$"

//--- source/csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   wstrobe,
  input  wire csr_map_pkg::csr_addr_e wr_addr,
  input  wire logic [31:0]            wdata,
  input  wire logic                   retire,
  output logic [63:0]                 mcycle,
  output logic [63:0]                 minstret
);

  logic [63:0] mcycle_nxt;
  logic [63:0] minstret_nxt;

  // A written half takes the operand, the other half keeps counting
  always_comb begin
    mcycle_nxt   = mcycle + 64'd1;
    minstret_nxt = retire ? minstret + 64'd1 : minstret;

    if (wstrobe) begin
      case (wr_addr)
        csr_map_pkg::csr_mcycle:    mcycle_nxt[31:0]    = wdata;
        csr_map_pkg::csr_mcycleh:   mcycle_nxt[63:32]   = wdata;
        csr_map_pkg::csr_minstret:  minstret_nxt[31:0]  = wdata;
        csr_map_pkg::csr_minstreth: minstret_nxt[63:32] = wdata;
        default: begin
          mcycle_nxt   = mcycle_nxt;
          minstret_nxt = minstret_nxt;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      mcycle   <= 64'b0;
      minstret <= 64'b0;
    end else begin
      mcycle   <= mcycle_nxt;
      minstret <= minstret_nxt;
    end
  end

endmodule

`default_nettype wire

//--- source/csr_field_pkg.sv
`default_nettype none

package csr_field_pkg;

  ////////////////////////////////////////
  // Field positions
  ////////////////////////////////////////

  // Global enable and its stacked copy in mstatus
  localparam int mie_bit  = 3;
  localparam int mpie_bit = 7;
  localparam int mpp_lsb  = 11;
  localparam int fs_lsb   = 13;

  // Machine sources in mip, also used for the matching mie enables
  localparam int meip_bit = 11;
  localparam int mtip_bit = 7;
  localparam int msip_bit = 3;

  ////////////////////////////////////////
  // Writable bits
  ////////////////////////////////////////

  // sd, tsr..mprv, xs, fs, mpp, spp, mpie, spie, upie, mie, sie, uie
  localparam logic [31:0] mstatus_wmask = 32'h807f_f9bb;

  // All three enables of each privilege level
  localparam logic [31:0] mie_wmask = 32'h0000_0bbb;

  // Machine pending bits come from the pins and are left out here
  localparam logic [31:0] mip_wmask = 32'h0000_0333;

  ////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////

  localparam logic [31:0] mstatus_reset = {19'b0, csr_map_pkg::m_mode, 11'b0};
  localparam logic [31:0] mtvec_reset = 32'h0000_0000;

endpackage

`default_nettype wire

//--- source/csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

  ////////////////////////////////////////
  // Machine-mode CSR address map
  ////////////////////////////////////////

  typedef enum logic [11:0] {
    csr_mstatus   = 12'h300,
    csr_misa      = 12'h301,
    csr_mie       = 12'h304,
    csr_mtvec     = 12'h305,
    csr_mscratch  = 12'h340,
    csr_mepc      = 12'h341,
    csr_mcause    = 12'h342,
    csr_mtval     = 12'h343,
    csr_mip       = 12'h344,
    csr_mcycle    = 12'hb00,
    csr_minstret  = 12'hb02,
    csr_mcycleh   = 12'hb80,
    csr_minstreth = 12'hb82,
    csr_mvendorid = 12'hf11,
    csr_marchid   = 12'hf12,
    csr_mimpid    = 12'hf13,
    csr_mhartid   = 12'hf14
  } csr_addr_e;

  ////////////////////////////////////////
  // Access operations and privilege levels
  ////////////////////////////////////////

  // Same encoding as the low two bits of funct3 for csrrw, csrrs and csrrc
  typedef enum logic [1:0] {
    op_write = 2'b01,
    op_set   = 2'b10,
    op_clear = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    u_mode = 2'b00,
    s_mode = 2'b01,
    m_mode = 2'b11
  } priv_e;

  // Machine interrupt cause codes
  typedef enum logic [3:0] {
    irq_soft  = 4'd3,
    irq_timer = 4'd7,
    irq_ext   = 4'd11
  } irq_cause_e;

  ////////////////////////////////////////
  // Identity
  ////////////////////////////////////////

  // RV32 with I, M, C and F
  localparam logic [31:0] misa_value = 32'h4000_1124;

endpackage

`default_nettype wire

//--- source/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    rd_en,
  input  wire csr_map_pkg::csr_addr_e  rd_addr,
  output logic [31:0]                  rd_data,
  input  wire csr_map_pkg::csr_addr_e  wr_addr,
  output logic [31:0]                  old_data,
  input  wire logic                    wstrobe,
  input  wire logic [31:0]             wdata,
  input  wire logic                    take_exc,
  input  wire logic                    take_irq,
  input  wire csr_map_pkg::irq_cause_e irq_cause,
  input  wire logic                    do_mret,
  input  wire logic [3:0]              exc_cause,
  input  wire logic [31:0]             exc_pc,
  input  wire logic [31:0]             exc_tval,
  input  wire logic                    meip,
  input  wire logic                    mtip,
  input  wire logic                    msip,
  input  wire logic [63:0]             mcycle,
  input  wire logic [63:0]             minstret,
  output logic                         mie_en,
  output logic                         meie,
  output logic                         mtie,
  output logic                         msie,
  output logic                         meip_q,
  output logic                         mtip_q,
  output logic                         msip_q,
  output logic [31:0]                  mtvec,
  output logic [31:0]                  mcause,
  output logic [31:0]                  epc,
  output logic [1:0]                   fs
);

  logic [31:0] mstatus_q;
  logic [31:0] mie_q;
  logic [31:0] mip_sw_q;
  logic [31:0] mscratch_q;
  logic [31:0] mepc_q;
  logic [31:0] mtval_q;
  logic [31:0] mip_rd;
  logic [31:0] mstatus_wr;
  logic        take;

  assign take = take_exc | take_irq;

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  always_comb begin
    mip_rd = mip_sw_q;
    mip_rd[csr_field_pkg::meip_bit] = meip_q;
    mip_rd[csr_field_pkg::mtip_bit] = mtip_q;
    mip_rd[csr_field_pkg::msip_bit] = msip_q;
  end

  function automatic logic [31:0] read_csr(input csr_map_pkg::csr_addr_e addr);
    logic [31:0] value;
    case (addr)
      csr_map_pkg::csr_misa:      value = csr_map_pkg::misa_value;
      csr_map_pkg::csr_mvendorid,
      csr_map_pkg::csr_marchid,
      csr_map_pkg::csr_mimpid,
      csr_map_pkg::csr_mhartid:   value = 32'b0;
      csr_map_pkg::csr_mstatus:   value = mstatus_q;
      csr_map_pkg::csr_mie:       value = mie_q;
      csr_map_pkg::csr_mip:       value = mip_rd;
      csr_map_pkg::csr_mtvec:     value = mtvec;
      csr_map_pkg::csr_mscratch:  value = mscratch_q;
      csr_map_pkg::csr_mepc:      value = mepc_q;
      csr_map_pkg::csr_mcause:    value = mcause;
      csr_map_pkg::csr_mtval:     value = mtval_q;
      csr_map_pkg::csr_mcycle:    value = mcycle[31:0];
      csr_map_pkg::csr_mcycleh:   value = mcycle[63:32];
      csr_map_pkg::csr_minstret:  value = minstret[31:0];
      csr_map_pkg::csr_minstreth: value = minstret[63:32];
      default:                    value = 32'b0;
    endcase
    return value;
  endfunction

  always_comb begin
    rd_data  = rd_en ? read_csr(rd_addr) : 32'b0;
    old_data = read_csr(wr_addr);
  end

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  // mpp only holds levels that exist on this hart
  always_comb begin
    mstatus_wr = (mstatus_q & ~csr_field_pkg::mstatus_wmask) |
                 (wdata & csr_field_pkg::mstatus_wmask);
    if (wdata[csr_field_pkg::mpp_lsb +: 2] != csr_map_pkg::m_mode &&
        wdata[csr_field_pkg::mpp_lsb +: 2] != csr_map_pkg::u_mode) begin
      mstatus_wr[csr_field_pkg::mpp_lsb +: 2] = mstatus_q[csr_field_pkg::mpp_lsb +: 2];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      mstatus_q  <= csr_field_pkg::mstatus_reset;
      mie_q      <= 32'b0;
      mip_sw_q   <= 32'b0;
      mtvec      <= csr_field_pkg::mtvec_reset;
      mscratch_q <= 32'b0;
      mepc_q     <= 32'b0;
      mcause     <= 32'b0;
      mtval_q    <= 32'b0;
      meip_q     <= 1'b0;
      mtip_q     <= 1'b0;
      msip_q     <= 1'b0;
    end else begin
      meip_q <= meip;
      mtip_q <= mtip;
      msip_q <= msip;

      if (wstrobe) begin
        case (wr_addr)
          csr_map_pkg::csr_mstatus:  mstatus_q <= mstatus_wr;
          csr_map_pkg::csr_mie:      mie_q <= wdata & csr_field_pkg::mie_wmask;
          csr_map_pkg::csr_mip:      mip_sw_q <= wdata & csr_field_pkg::mip_wmask;
          csr_map_pkg::csr_mtvec:    mtvec <= wdata;
          csr_map_pkg::csr_mscratch: mscratch_q <= wdata;
          csr_map_pkg::csr_mepc:     mepc_q <= wdata;
          csr_map_pkg::csr_mcause:   mcause <= wdata;
          csr_map_pkg::csr_mtval:    mtval_q <= wdata;
          default: mscratch_q <= mscratch_q;
        endcase
      end

      // Trap entry overrides a CSR write in the same cycle
      if (take) begin
        mstatus_q[csr_field_pkg::mpie_bit] <= mstatus_q[csr_field_pkg::mie_bit];
        mstatus_q[csr_field_pkg::mie_bit]  <= 1'b0;
        mepc_q  <= exc_pc;
        mtval_q <= exc_tval;
        if (take_exc) begin
          mcause <= {28'b0, exc_cause};
        end else begin
          mcause <= {1'b1, 27'b0, irq_cause};
        end
      end

      // Return from trap is applied last
      if (do_mret) begin
        mstatus_q[csr_field_pkg::mie_bit]  <= mstatus_q[csr_field_pkg::mpie_bit];
        mstatus_q[csr_field_pkg::mpie_bit] <= 1'b1;
      end
    end
  end

  assign mie_en = mstatus_q[csr_field_pkg::mie_bit];
  assign meie   = mie_q[csr_field_pkg::meip_bit];
  assign mtie   = mie_q[csr_field_pkg::mtip_bit];
  assign msie   = mie_q[csr_field_pkg::msip_bit];
  assign epc    = mepc_q;
  assign fs     = mstatus_q[csr_field_pkg::fs_lsb +: 2];

endmodule

`default_nettype wire

//--- source/csr_rmw.sv
`timescale 1ns/1ps
`default_nettype none

module csr_rmw (
  input  wire logic                 wr_en,
  input  wire csr_map_pkg::csr_op_e wr_op,
  input  wire logic [31:0]          wr_operand,
  input  wire logic [31:0]          old_data,
  output logic [31:0]               wdata,
  output logic                      wstrobe
);

  always_comb begin
    wdata   = old_data;
    wstrobe = 1'b0;
    case (wr_op)
      csr_map_pkg::op_write: begin
        wdata   = wr_operand;
        wstrobe = wr_en;
      end
      csr_map_pkg::op_set: begin
        wdata   = old_data | wr_operand;
        // A zero mask reads only and has no write side effect
        wstrobe = wr_en && (wr_operand != 32'b0);
      end
      csr_map_pkg::op_clear: begin
        wdata   = old_data & ~wr_operand;
        wstrobe = wr_en && (wr_operand != 32'b0);
      end
      default: begin
        wdata   = old_data;
        wstrobe = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/csr_trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_trap_ctrl (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                exc_valid,
  input  wire logic                retire,
  input  wire logic                mret_req,
  input  wire logic                mie_en,
  input  wire logic                meie,
  input  wire logic                mtie,
  input  wire logic                msie,
  input  wire logic                meip_q,
  input  wire logic                mtip_q,
  input  wire logic                msip_q,
  input  wire logic [31:0]         mtvec,
  input  wire logic [31:0]         mcause,
  output logic                     take_exc,
  output logic                     take_irq,
  output csr_map_pkg::irq_cause_e  irq_cause,
  output logic                     do_mret,
  output logic                     trap,
  output logic                     mret,
  output logic [31:0]              trap_vector
);

  logic ext_ready;
  logic timer_ready;
  logic soft_ready;
  logic [31:0] vec_base;

  ////////////////////////////////////////
  // Source selection
  ////////////////////////////////////////

  assign ext_ready   = meie & meip_q;
  assign timer_ready = mtie & mtip_q;
  assign soft_ready  = msie & msip_q;

  // Exceptions always win, interrupts are taken only at a retiring instruction
  assign take_exc = exc_valid;
  assign take_irq = !exc_valid && retire && mie_en &&
                    (ext_ready || timer_ready || soft_ready);

  always_comb begin
    if (ext_ready) begin
      irq_cause = csr_map_pkg::irq_ext;
    end else if (timer_ready) begin
      irq_cause = csr_map_pkg::irq_timer;
    end else begin
      irq_cause = csr_map_pkg::irq_soft;
    end
  end

  assign do_mret = mret_req;

  ////////////////////////////////////////
  // Output pulses
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      trap <= 1'b0;
      mret <= 1'b0;
    end else begin
      trap <= take_exc | take_irq;
      mret <= do_mret;
    end
  end

  ////////////////////////////////////////
  // Trap target
  ////////////////////////////////////////

  assign vec_base = {mtvec[31:2], 2'b00};

  // Vectored mode only applies to interrupt causes
  always_comb begin
    if (mtvec[1:0] == 2'b01 && mcause[31]) begin
      trap_vector = vec_base + {mcause[29:0], 2'b00};
    end else begin
      trap_vector = vec_base;
    end
  end

endmodule

`default_nettype wire

//--- source/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   rd_en,
  input  wire csr_map_pkg::csr_addr_e rd_addr,
  output logic [31:0]                 rd_data,
  input  wire logic                   wr_en,
  input  wire csr_map_pkg::csr_op_e   wr_op,
  input  wire csr_map_pkg::csr_addr_e wr_addr,
  input  wire logic [31:0]            wr_operand,
  input  wire logic                   retire,
  input  wire logic                   exc_valid,
  input  wire logic [3:0]             exc_cause,
  input  wire logic [31:0]            exc_pc,
  input  wire logic [31:0]            exc_tval,
  input  wire logic                   mret_req,
  input  wire logic                   meip,
  input  wire logic                   mtip,
  input  wire logic                   msip,
  output logic                        trap,
  output logic                        mret,
  output logic [31:0]                 trap_vector,
  output logic [31:0]                 epc,
  output logic [1:0]                  fs
);

  logic [31:0] old_data;
  logic [31:0] wdata;
  logic        wstrobe;
  logic [63:0] mcycle;
  logic [63:0] minstret;
  logic        mie_en;
  logic        meie;
  logic        mtie;
  logic        msie;
  logic        meip_q;
  logic        mtip_q;
  logic        msip_q;
  logic [31:0] mtvec;
  logic [31:0] mcause;
  logic        take_exc;
  logic        take_irq;
  logic        do_mret;
  csr_map_pkg::irq_cause_e irq_cause;

  csr_rmw u_rmw (
    .wr_en, .wr_op, .wr_operand, .old_data, .wdata, .wstrobe
  );

  csr_counters u_counters (
    .clk, .rst, .wstrobe, .wr_addr, .wdata, .retire, .mcycle, .minstret
  );

  csr_trap_ctrl u_trap_ctrl (
    .clk, .rst, .exc_valid, .retire, .mret_req,
    .mie_en, .meie, .mtie, .msie, .meip_q, .mtip_q, .msip_q,
    .mtvec, .mcause,
    .take_exc, .take_irq, .irq_cause, .do_mret,
    .trap, .mret, .trap_vector
  );

  csr_regfile u_regfile (
    .clk, .rst,
    .rd_en, .rd_addr, .rd_data,
    .wr_addr, .old_data, .wstrobe, .wdata,
    .take_exc, .take_irq, .irq_cause, .do_mret,
    .exc_cause, .exc_pc, .exc_tval,
    .meip, .mtip, .msip,
    .mcycle, .minstret,
    .mie_en, .meie, .mtie, .msie, .meip_q, .mtip_q, .msip_q,
    .mtvec, .mcause,
    .epc, .fs
  );

endmodule

`default_nettype wire

//--- verif/csr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csr_checker (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   rd_en,
  input  wire csr_map_pkg::csr_addr_e rd_addr,
  input  wire logic [31:0]            rd_data,
  input  wire logic                   wr_en,
  input  wire csr_map_pkg::csr_op_e   wr_op,
  input  wire csr_map_pkg::csr_addr_e wr_addr,
  input  wire logic [31:0]            wr_operand,
  input  wire logic                   retire,
  input  wire logic                   exc_valid,
  input  wire logic [3:0]             exc_cause,
  input  wire logic [31:0]            exc_pc,
  input  wire logic [31:0]            exc_tval,
  input  wire logic                   mret_req,
  input  wire logic                   meip,
  input  wire logic                   mtip,
  input  wire logic                   msip,
  input  wire logic                   trap,
  input  wire logic                   mret,
  input  wire logic [31:0]            trap_vector,
  input  wire logic [31:0]            epc,
  input  wire logic [1:0]             fs,
  output int                          errors
);

  // Model of the machine registers, pins and counters
  logic [31:0] m_status;
  logic [31:0] m_ie;
  logic [31:0] m_ip_sw;
  logic [31:0] m_tvec;
  logic [31:0] m_scratch;
  logic [31:0] m_epc;
  logic [31:0] m_cause;
  logic [31:0] m_tval;
  logic [2:0]  m_pend;
  logic [63:0] m_cycle;
  logic [63:0] m_instret;
  logic        m_trap;
  logic        m_mret;

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    logic [31:0] mip_v;
    mip_v = m_ip_sw;
    mip_v[11] = m_pend[2];
    mip_v[7] = m_pend[1];
    mip_v[3] = m_pend[0];
    case (addr)
      12'h300: return m_status;
      12'h301: return 32'h4000_1124;
      12'h304: return m_ie;
      12'h305: return m_tvec;
      12'h340: return m_scratch;
      12'h341: return m_epc;
      12'h342: return m_cause;
      12'h343: return m_tval;
      12'h344: return mip_v;
      12'hb00: return m_cycle[31:0];
      12'hb80: return m_cycle[63:32];
      12'hb02: return m_instret[31:0];
      12'hb82: return m_instret[63:32];
      default: return 32'b0;
    endcase
  endfunction

  // Vectored mode adds four times the cause for interrupts only
  function automatic logic [31:0] model_vector();
    logic [31:0] base;
    base = {m_tvec[31:2], 2'b00};
    if (m_tvec[1:0] == 2'b01 && m_cause[31]) begin
      return base + (m_cause & 32'h3fff_ffff) * 4;
    end
    return base;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic reset_model();
    m_status  = 32'h0000_1800;
    m_ie      = 32'b0;
    m_ip_sw   = 32'b0;
    m_tvec    = 32'b0;
    m_scratch = 32'b0;
    m_epc     = 32'b0;
    m_cause   = 32'b0;
    m_tval    = 32'b0;
    m_pend    = 3'b0;
    m_cycle   = 64'b0;
    m_instret = 64'b0;
    m_trap    = 1'b0;
    m_mret    = 1'b0;
  endtask

  task automatic step_model();
    logic [31:0] old;
    logic [31:0] wd;
    logic [31:0] st0;
    logic        ws;
    logic        take_irq;
    logic [3:0]  cause;
    old = model_read(wr_addr);
    st0 = m_status;
    ws = 1'b0;
    wd = old;
    case (wr_op)
      csr_map_pkg::op_write: begin
        wd = wr_operand;
        ws = wr_en;
      end
      csr_map_pkg::op_set: begin
        wd = old | wr_operand;
        ws = wr_en && wr_operand != 32'b0;
      end
      csr_map_pkg::op_clear: begin
        wd = old & ~wr_operand;
        ws = wr_en && wr_operand != 32'b0;
      end
      default: ws = 1'b0;
    endcase
    take_irq = !exc_valid && retire && st0[3] &&
               ((m_ie[11] && m_pend[2]) || (m_ie[7] && m_pend[1]) || (m_ie[3] && m_pend[0]));
    cause = (m_ie[11] && m_pend[2]) ? 4'd11 : (m_ie[7] && m_pend[1]) ? 4'd7 : 4'd3;
    m_cycle = m_cycle + 64'd1;
    m_instret = m_instret + {63'b0, retire};
    if (ws) begin
      case (wr_addr)
        csr_map_pkg::csr_mstatus: begin
          // An mpp value other than m_mode or u_mode keeps the old one
          if (wd[12:11] == 2'b10 || wd[12:11] == 2'b01) begin
            wd[12:11] = m_status[12:11];
          end
          m_status = (m_status & ~csr_field_pkg::mstatus_wmask) |
                     (wd & csr_field_pkg::mstatus_wmask);
        end
        csr_map_pkg::csr_mie:       m_ie = wd & csr_field_pkg::mie_wmask;
        csr_map_pkg::csr_mip:       m_ip_sw = wd & csr_field_pkg::mip_wmask;
        csr_map_pkg::csr_mtvec:     m_tvec = wd;
        csr_map_pkg::csr_mscratch:  m_scratch = wd;
        csr_map_pkg::csr_mepc:      m_epc = wd;
        csr_map_pkg::csr_mcause:    m_cause = wd;
        csr_map_pkg::csr_mtval:     m_tval = wd;
        csr_map_pkg::csr_mcycle:    m_cycle[31:0] = wd;
        csr_map_pkg::csr_mcycleh:   m_cycle[63:32] = wd;
        csr_map_pkg::csr_minstret:  m_instret[31:0] = wd;
        csr_map_pkg::csr_minstreth: m_instret[63:32] = wd;
        default: ws = 1'b0;
      endcase
    end
    if (exc_valid || take_irq) begin
      m_status[7] = st0[3];
      m_status[3] = 1'b0;
      m_epc = exc_pc;
      m_tval = exc_tval;
      m_cause = exc_valid ? {28'b0, exc_cause} : {1'b1, 27'b0, cause};
    end
    if (mret_req) begin
      m_status[3] = st0[7];
      m_status[7] = 1'b1;
    end
    m_pend = {meip, mtip, msip};
    m_trap = exc_valid || take_irq;
    m_mret = mret_req;
  endtask

  ////////////////////////////////////////
  // Compare before each edge, then step
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst) begin
      reset_model();
    end else begin
      check_value("rd_data", rd_en ? model_read(rd_addr) : 32'b0, rd_data);
      check_value("trap", {31'b0, m_trap}, {31'b0, trap});
      check_value("mret", {31'b0, m_mret}, {31'b0, mret});
      check_value("trap_vector", model_vector(), trap_vector);
      check_value("epc", m_epc, epc);
      check_value("fs", {30'b0, m_status[14:13]}, {30'b0, fs});
      step_model();
    end
  end

endmodule

`default_nettype wire

//--- verif/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

  // Cycles of reset and of each test, in order
  localparam int test_cycles = 3 + 42 + 37 + 9 + 96 + 7 + 302;
  localparam int cycle_limit = test_cycles + 200;

  localparam logic [11:0] addr_tab [18] = '{
    12'h300, 12'h301, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343, 12'h344,
    12'hb00, 12'hb80, 12'hb02, 12'hb82, 12'hf11, 12'hf12, 12'hf13, 12'hf14, 12'h7c0
  };

  logic clk;
  logic rst;
  logic rd_en;
  logic wr_en;
  logic retire;
  logic exc_valid;
  logic mret_req;
  logic meip;
  logic mtip;
  logic msip;
  logic trap;
  logic mret;
  logic [1:0]  fs;
  logic [3:0]  exc_cause;
  logic [31:0] wr_operand;
  logic [31:0] exc_pc;
  logic [31:0] exc_tval;
  logic [31:0] rd_data;
  logic [31:0] trap_vector;
  logic [31:0] epc;
  csr_map_pkg::csr_addr_e rd_addr;
  csr_map_pkg::csr_addr_e wr_addr;
  csr_map_pkg::csr_op_e   wr_op;
  int errors;
  int errors_before;
  int cycle_count;

  csr_unit DUT (.*);

  csr_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // One access, with the read port on the same address
  task automatic access(input csr_map_pkg::csr_op_e op, input logic [11:0] addr,
                        input logic [31:0] value);
    wr_en      = 1'b1;
    wr_op      = op;
    wr_addr    = csr_map_pkg::csr_addr_e'(addr);
    wr_operand = value;
    rd_en      = 1'b1;
    rd_addr    = csr_map_pkg::csr_addr_e'(addr);
    idle(1);
    wr_en = 1'b0;
    idle(1);
  endtask

  task automatic look(input logic [11:0] addr);
    rd_en   = 1'b1;
    rd_addr = csr_map_pkg::csr_addr_e'(addr);
    idle(1);
  endtask

  task automatic finish_test(input string name);
    $display("%s done with %0d mismatches", name, errors - errors_before);
    errors_before = errors;
  endtask

  initial begin
    rst = 1'b0;
    rd_en = 1'b0;
    rd_addr = csr_map_pkg::csr_mstatus;
    wr_en = 1'b0;
    wr_op = csr_map_pkg::op_write;
    wr_addr = csr_map_pkg::csr_mscratch;
    wr_operand = 32'b0;
    retire = 1'b0;
    exc_valid = 1'b0;
    exc_cause = 4'd0;
    exc_pc = 32'b0;
    exc_tval = 32'b0;
    mret_req = 1'b0;
    meip = 1'b0;
    mtip = 1'b0;
    msip = 1'b0;
    errors_before = 0;
    void'($urandom(32'h36a6_869a));
    idle(3);
    rst = 1'b1;

    access(csr_map_pkg::op_write, 12'h340, 32'hdead_beef);
    access(csr_map_pkg::op_set, 12'h340, 32'h0000_00ff);
    access(csr_map_pkg::op_clear, 12'h340, 32'h0000_f0f0);
    // A zero operand must leave the counter running
    access(csr_map_pkg::op_set, 12'hb00, 32'h0);
    access(csr_map_pkg::op_clear, 12'hb00, 32'h0);
    access(csr_map_pkg::op_write, 12'h305, 32'h1000_0101);
    access(csr_map_pkg::op_write, 12'h341, 32'h0000_4444);
    access(csr_map_pkg::op_write, 12'h304, 32'hffff_ffff);
    access(csr_map_pkg::op_clear, 12'h304, 32'h0000_0808);
    access(csr_map_pkg::op_write, 12'h300, 32'hffff_ffff);
    // s_mode in mpp must be ignored
    access(csr_map_pkg::op_write, 12'h300, 32'h0000_0800);
    access(csr_map_pkg::op_write, 12'h300, 32'h0);
    for (int i = 0; i < 18; i++) look(addr_tab[i]);
    finish_test("test 1 access operations");

    look(12'hb00);
    look(12'hb80);
    retire = 1'b1;
    idle(5);
    retire = 1'b0;
    access(csr_map_pkg::op_write, 12'hb00, 32'hffff_fff0);
    for (int i = 0; i < 20; i++) look((i % 2 == 0) ? 12'hb00 : 12'hb80);
    access(csr_map_pkg::op_write, 12'hb80, 32'h0000_0007);
    retire = 1'b1;
    access(csr_map_pkg::op_write, 12'hb02, 32'hffff_fffe);
    look(12'hb82);
    access(csr_map_pkg::op_write, 12'hb82, 32'h0000_0100);
    retire = 1'b0;
    look(12'hb02);
    finish_test("test 2 counters");

    access(csr_map_pkg::op_write, 12'h305, 32'h0000_2000);
    access(csr_map_pkg::op_set, 12'h300, 32'h0000_0008);
    exc_valid = 1'b1;
    exc_cause = 4'd2;
    exc_pc = 32'h0000_1234;
    exc_tval = 32'hbad0_0001;
    look(12'h342);
    exc_valid = 1'b0;
    look(12'h342);
    look(12'h341);
    look(12'h343);
    look(12'h300);
    finish_test("test 3 exceptions");

    access(csr_map_pkg::op_write, 12'h305, 32'h0000_3001);
    access(csr_map_pkg::op_write, 12'h304, 32'h0000_0888);
    access(csr_map_pkg::op_set, 12'h300, 32'h0000_0088);
    for (int i = 0; i < 16; i++) begin
      if (i == 8) access(csr_map_pkg::op_clear, 12'h304, 32'h0000_0080);
      if (i >= 12) access(csr_map_pkg::op_clear, 12'h300, 32'h0000_0008);
      {meip, mtip, msip} = i[2:0];
      idle(2);
      retire = i[3] || i[0];
      look(12'h342);
      retire = 1'b0;
      {meip, mtip, msip} = 3'b0;
      look(12'h342);
      mret_req = 1'b1;
      idle(1);
      mret_req = 1'b0;
    end
    finish_test("test 4 interrupts");

    access(csr_map_pkg::op_write, 12'h300, 32'h0000_0080);
    mret_req = 1'b1;
    look(12'h300);
    mret_req = 1'b0;
    look(12'h300);
    exc_valid = 1'b1;
    mret_req = 1'b1;
    look(12'h300);
    exc_valid = 1'b0;
    mret_req = 1'b0;
    idle(2);
    finish_test("test 5 mret");

    for (int i = 0; i < 300; i++) begin
      rd_en = ($urandom % 2) == 0;
      rd_addr = csr_map_pkg::csr_addr_e'(addr_tab[$urandom % 18]);
      wr_en = ($urandom % 4) == 0;
      wr_op = csr_map_pkg::csr_op_e'(2'($urandom_range(1, 3)));
      wr_addr = csr_map_pkg::csr_addr_e'(addr_tab[$urandom % 18]);
      wr_operand = $urandom;
      retire = ($urandom % 2) == 0;
      exc_valid = ($urandom % 16) == 0;
      exc_cause = 4'($urandom);
      exc_pc = $urandom;
      exc_tval = $urandom;
      mret_req = ($urandom % 16) == 0;
      meip = ($urandom % 4) == 0;
      mtip = ($urandom % 4) == 0;
      msip = ($urandom % 4) == 0;
      idle(1);
    end
    wr_en = 1'b0;
    exc_valid = 1'b0;
    mret_req = 1'b0;
    idle(2);
    finish_test("test 6 random mix");

    $display("Tests run 6, mismatches %0d, cycles %0d", errors, cycle_count);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
